// ==== include/pipe_defs.svh ====
`ifndef PIPE_DEFS_SVH
`define PIPE_DEFS_SVH

// Program counter width, counted in instruction words
`define PC_W 16

// Instruction word width
`define INST_W 16

// Number of entries in the issue FIFO
`define FIFO_DEPTH 4

// Width of a register index field
`define REG_W 4

`endif

// ==== design/pipe_pkg.sv ====
`include "pipe_defs.svh"

package pipe_pkg;

    typedef enum logic [3:0] {
        OP_NOP    = 4'd0,
        OP_ALU    = 4'd1,
        OP_LOAD   = 4'd2,
        OP_STORE  = 4'd3,
        OP_BRANCH = 4'd4
    } opcode_e;

    // Register to register format
    typedef struct packed {
        opcode_e           op;
        logic [`REG_W-1:0] rd;
        logic [`REG_W-1:0] rs;
        logic [`REG_W-1:0] rt;
    } alu_fmt_t;

    // Memory and branch format, off is a signed word offset
    typedef struct packed {
        opcode_e                  op;
        logic [`REG_W-1:0]        rd;
        logic [`REG_W-1:0]        rs;
        logic signed [`REG_W-1:0] off;
    } mem_fmt_t;

    // Both views share the opcode in the top nibble
    typedef union packed {
        alu_fmt_t alu_fmt;
        mem_fmt_t mem_fmt;
    } inst_u;

endpackage

// ==== design/pipe_ctrl.sv ====
module pipe_ctrl (
    input  logic i_cache_stall_req,
    input  logic d_cache_stall_req,
    input  logic fifo_stall_req,
    input  logic forwardc_req,
    input  logic forwardp_req,
    input  logic b_ctrl_flush_req,
    // Set when the delay slot of the branch in ex has not reached id2 yet
    input  logic with_delaysolt,
    input  logic exc_stall_req,
    input  logic exception_flush,
    input  logic lsu1_tlb_stall_req,
    input  logic mem_refetch,

    output logic ex_lsu1_flush,
    output logic ex_lsu1_exp_flush,
    output logic ex_lsu1_stall,
    output logic lsu1_lsu2_flush,
    output logic lsu1_lsu2_exp_flush,
    output logic lsu1_lsu2_stall,
    output logic pc_stall,
    output logic fifo_flush,
    output logic issue_stall,
    output logic ii_id2_flush,
    output logic ii_id2_exception_flush,
    output logic ii_id2_stall,
    output logic id2_ex_flush,
    output logic id2_ex_exception_flush,
    output logic id2_ex_stall,
    output logic mem_wb_stall,
    output logic wb_stall
);
    logic exc_any;
    logic hazard;
    logic cache_stall;

    assign exc_any     = exception_flush | mem_refetch;
    assign hazard      = forwardc_req | forwardp_req;
    assign cache_stall = i_cache_stall_req | d_cache_stall_req;

    // Everything ahead of write-back is dropped on an exception or refetch
    assign ii_id2_exception_flush = exc_any;
    assign id2_ex_exception_flush = exc_any;
    assign ex_lsu1_exp_flush      = exc_any;
    assign lsu1_lsu2_exp_flush    = exc_any;

    assign pc_stall = fifo_stall_req;

    // A branch only clears the FIFO once the issuing word is free of hazards
    assign fifo_flush = (b_ctrl_flush_req & ~hazard) | exc_any;

    assign issue_stall = cache_stall | hazard | exc_stall_req | lsu1_tlb_stall_req;

    assign ii_id2_flush = b_ctrl_flush_req;
    assign ii_id2_stall = cache_stall | issue_stall | (pc_stall & fifo_flush) | hazard
                          | exc_stall_req | lsu1_tlb_stall_req;

    // A hazard holds the front end and lets a bubble into ex
    assign id2_ex_flush = (b_ctrl_flush_req & with_delaysolt) | hazard;
    assign id2_ex_stall = cache_stall | exc_stall_req | lsu1_tlb_stall_req;

    // A TLB miss in lsu1 keeps the older stages moving and drops the word entering lsu1
    assign ex_lsu1_flush = lsu1_tlb_stall_req;
    assign ex_lsu1_stall = cache_stall | exc_stall_req;

    assign lsu1_lsu2_flush = 1'b0;
    assign lsu1_lsu2_stall = cache_stall | exc_stall_req;

    // The exception unit may not hold write-back while it is flushing
    assign mem_wb_stall = cache_stall | (exc_stall_req & ~exc_any);
    assign wb_stall     = cache_stall | (exc_stall_req & ~exc_any);

endmodule

// ==== design/inst_fifo.sv ====
`include "pipe_defs.svh"

module inst_fifo (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               push,
    input  logic [`PC_W-1:0]   push_pc,
    input  pipe_pkg::inst_u    push_inst,
    input  logic               pop,
    input  logic               flush,
    output logic               full,
    output logic               empty,
    output logic [`PC_W-1:0]   head_pc,
    output pipe_pkg::inst_u    head_inst
);
    import pipe_pkg::*;

    localparam int AW = $clog2(`FIFO_DEPTH);
    localparam logic [AW-1:0] LAST_PTR = AW'(`FIFO_DEPTH - 1);
    localparam logic [AW:0] DEPTH_CNT = (AW + 1)'(`FIFO_DEPTH);

    logic [AW-1:0]     wr_ptr;
    logic [AW-1:0]     rd_ptr;
    logic [AW:0]       count;
    logic              do_push;
    logic              do_pop;
    logic [`PC_W-1:0]  pc_mem [`FIFO_DEPTH];
    inst_u             inst_mem [`FIFO_DEPTH];

    assign full    = (count == DEPTH_CNT);
    assign empty   = (count == '0);
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    assign head_pc   = pc_mem[rd_ptr];
    assign head_inst = inst_mem[rd_ptr];

    // A flush wins over a push in the same cycle, so stale fetches are dropped
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push && !flush) begin
            pc_mem[wr_ptr]   <= push_pc;
            inst_mem[wr_ptr] <= push_inst;
        end
    end

endmodule

// ==== design/stage_reg.sv ====
module stage_reg #(
    parameter int W = 32
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         stall,
    input  logic         flush,
    input  logic         exp_flush,
    input  logic         in_valid,
    input  logic [W-1:0] in_data,
    output logic         out_valid,
    output logic [W-1:0] out_data
);

    // Exception flush beats flush, and both beat stall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (exp_flush || flush) begin
            out_valid <= 1'b0;
        end else if (!stall) begin
            out_valid <= in_valid;
        end
    end

    // Payload is only meaningful while out_valid is set
    always_ff @(posedge clk) begin
        if (!stall) begin
            out_data <= in_data;
        end
    end

endmodule

// ==== design/hazard_unit.sv ====
`include "pipe_defs.svh"

module hazard_unit (
    input  logic            issue_valid,
    input  pipe_pkg::inst_u issue_inst,
    input  logic            id2_valid,
    input  pipe_pkg::inst_u id2_inst,
    input  logic            ex_valid,
    input  pipe_pkg::inst_u ex_inst,
    output logic            forwardc_req,
    output logic            forwardp_req
);
    import pipe_pkg::*;

    logic              use_rs;
    logic              use_rt;
    logic [`REG_W-1:0] src_rs;
    logic [`REG_W-1:0] src_rt;
    logic              id2_hit;
    logic              ex_hit;

    // Which source fields the issuing word actually reads
    always_comb begin
        use_rs = 1'b0;
        use_rt = 1'b0;
        case (issue_inst.alu_fmt.op)
            OP_ALU: begin
                use_rs = 1'b1;
                use_rt = 1'b1;
            end
            OP_LOAD, OP_STORE, OP_BRANCH: begin
                use_rs = 1'b1;
            end
            default: begin
                use_rs = 1'b0;
            end
        endcase
    end

    assign src_rs = issue_inst.mem_fmt.rs;
    assign src_rt = issue_inst.alu_fmt.rt;

    assign id2_hit = (use_rs && (src_rs == id2_inst.mem_fmt.rd))
                  || (use_rt && (src_rt == id2_inst.mem_fmt.rd));
    assign ex_hit  = (use_rs && (src_rs == ex_inst.mem_fmt.rd))
                  || (use_rt && (src_rt == ex_inst.mem_fmt.rd));

    // Producer valids come in already qualified as loads
    assign forwardp_req = issue_valid & id2_valid & id2_hit;
    assign forwardc_req = issue_valid & ex_valid & ex_hit;

endmodule

// ==== design/branch_unit.sv ====
`include "pipe_defs.svh"

module branch_unit (
    input  logic               ex_valid,
    input  logic [`PC_W-1:0]   ex_pc,
    input  pipe_pkg::inst_u    ex_inst,
    input  logic               id2_valid,
    output logic               b_ctrl_flush_req,
    output logic               with_delaysolt,
    output logic               redirect_valid,
    output logic [`PC_W-1:0]   redirect_pc
);
    import pipe_pkg::*;

    logic              is_branch;
    logic [`PC_W-1:0]  off_ext;

    // All branches are taken
    assign is_branch = ex_valid & (ex_inst.mem_fmt.op == OP_BRANCH);

    assign off_ext = {{(`PC_W - `REG_W){ex_inst.mem_fmt.off[`REG_W-1]}},
                      ex_inst.mem_fmt.off};

    // Target is relative to the delay slot
    assign redirect_pc = ex_pc + `PC_W'(1) + off_ext;

    assign b_ctrl_flush_req = is_branch;
    assign redirect_valid   = is_branch;

    // An empty id2 means the delay slot is still waiting in issue
    assign with_delaysolt = is_branch & ~id2_valid;

endmodule

// ==== design/pipe_top.sv ====
`include "pipe_defs.svh"

module pipe_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               fetch_valid,
    input  logic [`PC_W-1:0]   fetch_pc,
    input  pipe_pkg::inst_u    fetch_inst,
    input  logic               i_cache_stall_req,
    input  logic               d_cache_stall_req,
    input  logic               exc_stall_req,
    input  logic               lsu1_tlb_stall_req,
    input  logic               exception_flush,
    input  logic               mem_refetch,
    output logic               fetch_ready,
    output logic               redirect_valid,
    output logic [`PC_W-1:0]   redirect_pc,
    output logic               wb_valid,
    output logic [`PC_W-1:0]   wb_pc,
    output pipe_pkg::inst_u    wb_inst
);
    import pipe_pkg::*;

    localparam int PW = `PC_W + `INST_W;
    localparam int LW = PW + 1;

    logic fifo_full, fifo_empty, exc_any;
    logic [`PC_W-1:0] head_pc, ex_pc;
    inst_u head_inst, id2_inst, ex_inst, lsu1_inst;
    logic id2_valid, ex_valid, lsu1_valid, lsu2_valid, wbr_valid;
    logic [PW-1:0] id2_data, lsu2_data, wbr_data;
    logic [LW-1:0] ex_data, lsu1_data;
    logic id2_load, ex_load, lsu1_load;
    logic forwardc_req, forwardp_req, b_ctrl_flush_req, with_delaysolt;
    logic ex_lsu1_flush, ex_lsu1_exp_flush, ex_lsu1_stall;
    logic lsu1_lsu2_flush, lsu1_lsu2_exp_flush, lsu1_lsu2_stall;
    logic pc_stall, fifo_flush, issue_stall, mem_wb_stall, wb_stall;
    logic ii_id2_flush, ii_id2_exception_flush, ii_id2_stall;
    logic id2_ex_flush, id2_ex_exception_flush, id2_ex_stall;

    assign exc_any     = exception_flush | mem_refetch;
    assign fetch_ready = ~pc_stall;

    inst_fifo u_fifo (
        .clk(clk), .rst_n(rst_n), .push(fetch_valid & fetch_ready), .push_pc(fetch_pc),
        .push_inst(fetch_inst), .pop(~issue_stall), .flush(fifo_flush),
        .full(fifo_full), .empty(fifo_empty), .head_pc(head_pc), .head_inst(head_inst)
    );

    stage_reg #(.W(PW)) u_ii_id2 (
        .clk(clk), .rst_n(rst_n), .stall(ii_id2_stall), .flush(ii_id2_flush),
        .exp_flush(ii_id2_exception_flush), .in_valid(~fifo_empty),
        .in_data({head_pc, head_inst}), .out_valid(id2_valid), .out_data(id2_data)
    );

    assign id2_inst = id2_data[`INST_W-1:0];
    assign id2_load = (id2_inst.mem_fmt.op == OP_LOAD);

    // From id2 to lsu1 the payload carries a load flag for the hazard check
    stage_reg #(.W(LW)) u_id2_ex (
        .clk(clk), .rst_n(rst_n), .stall(id2_ex_stall), .flush(id2_ex_flush),
        .exp_flush(id2_ex_exception_flush), .in_valid(id2_valid),
        .in_data({id2_load, id2_data}), .out_valid(ex_valid), .out_data(ex_data)
    );

    assign ex_load = ex_data[LW-1];
    assign ex_pc   = ex_data[PW-1:`INST_W];
    assign ex_inst = ex_data[`INST_W-1:0];

    stage_reg #(.W(LW)) u_ex_lsu1 (
        .clk(clk), .rst_n(rst_n), .stall(ex_lsu1_stall), .flush(ex_lsu1_flush),
        .exp_flush(ex_lsu1_exp_flush), .in_valid(ex_valid), .in_data(ex_data),
        .out_valid(lsu1_valid), .out_data(lsu1_data)
    );

    assign lsu1_load = lsu1_data[LW-1];
    assign lsu1_inst = lsu1_data[`INST_W-1:0];

    stage_reg #(.W(PW)) u_lsu1_lsu2 (
        .clk(clk), .rst_n(rst_n), .stall(lsu1_lsu2_stall), .flush(lsu1_lsu2_flush),
        .exp_flush(lsu1_lsu2_exp_flush), .in_valid(lsu1_valid), .in_data(lsu1_data[PW-1:0]),
        .out_valid(lsu2_valid), .out_data(lsu2_data)
    );

    stage_reg #(.W(PW)) u_lsu2_wb (
        .clk(clk), .rst_n(rst_n), .stall(mem_wb_stall), .flush(1'b0), .exp_flush(exc_any),
        .in_valid(lsu2_valid), .in_data(lsu2_data), .out_valid(wbr_valid), .out_data(wbr_data)
    );

    assign wb_valid = wbr_valid & ~wb_stall;
    assign wb_pc    = wbr_data[PW-1:`INST_W];
    assign wb_inst  = wbr_data[`INST_W-1:0];

    // The word leaving id2 is checked against loads in ex and lsu1
    hazard_unit u_hazard (
        .issue_valid(id2_valid), .issue_inst(id2_inst),
        .id2_valid(ex_valid & ex_load), .id2_inst(ex_inst),
        .ex_valid(lsu1_valid & lsu1_load), .ex_inst(lsu1_inst),
        .forwardc_req(forwardc_req), .forwardp_req(forwardp_req)
    );

    branch_unit u_branch (
        .ex_valid(ex_valid), .ex_pc(ex_pc), .ex_inst(ex_inst), .id2_valid(id2_valid),
        .b_ctrl_flush_req(b_ctrl_flush_req), .with_delaysolt(with_delaysolt),
        .redirect_valid(redirect_valid), .redirect_pc(redirect_pc)
    );

    pipe_ctrl u_ctrl (
        .i_cache_stall_req(i_cache_stall_req), .d_cache_stall_req(d_cache_stall_req),
        .fifo_stall_req(fifo_full), .forwardc_req(forwardc_req), .forwardp_req(forwardp_req),
        .b_ctrl_flush_req(b_ctrl_flush_req), .with_delaysolt(with_delaysolt),
        .exc_stall_req(exc_stall_req), .exception_flush(exception_flush),
        .lsu1_tlb_stall_req(lsu1_tlb_stall_req), .mem_refetch(mem_refetch),
        .ex_lsu1_flush(ex_lsu1_flush), .ex_lsu1_exp_flush(ex_lsu1_exp_flush),
        .ex_lsu1_stall(ex_lsu1_stall), .lsu1_lsu2_flush(lsu1_lsu2_flush),
        .lsu1_lsu2_exp_flush(lsu1_lsu2_exp_flush), .lsu1_lsu2_stall(lsu1_lsu2_stall),
        .pc_stall(pc_stall), .fifo_flush(fifo_flush), .issue_stall(issue_stall),
        .ii_id2_flush(ii_id2_flush), .ii_id2_exception_flush(ii_id2_exception_flush),
        .ii_id2_stall(ii_id2_stall), .id2_ex_flush(id2_ex_flush),
        .id2_ex_exception_flush(id2_ex_exception_flush), .id2_ex_stall(id2_ex_stall),
        .mem_wb_stall(mem_wb_stall), .wb_stall(wb_stall)
    );

endmodule

// ==== verification/clk_gen.sv ====
module clk_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Release reset just after an edge so it never races the clock
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #10;
        rst_n = 1'b1;
    end

endmodule

// ==== verification/pipe_tb.sv ====
`include "pipe_defs.svh"

module pipe_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import pipe_pkg::*;

    localparam int NUM_TESTS   = 6;
    localparam int CLK_PERIOD  = 100;
    localparam int DRAIN_LIMIT = 60;

    logic clk, rst_n;
    logic fetch_valid, fetch_ready;
    logic [`PC_W-1:0] fetch_pc, redirect_pc, wb_pc;
    inst_u fetch_inst, wb_inst;
    logic i_cache_stall_req, d_cache_stall_req, exc_stall_req, lsu1_tlb_stall_req;
    logic exception_flush, mem_refetch, redirect_valid, wb_valid;

    // Expected retirement order, one entry per accepted word
    logic [`PC_W-1:0] exp_pc [256];
    inst_u exp_inst [256];
    int exp_acc [256];
    logic exp_gap [256];
    logic [7:0] rd_idx, wr_idx, keep_idx, pending;
    int cyc, last_ret, held_cnt, redirect_cnt;
    logic br_armed;

    logic tag_gap, tag_slot, lat_check, fill_check;
    logic [`PC_W-1:0] exp_target, next_pc;
    int seed, err_count;

    clk_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(4)) u_clk (.clk(clk), .rst_n(rst_n));

    pipe_top DUT (
        .clk(clk), .rst_n(rst_n), .fetch_valid(fetch_valid), .fetch_pc(fetch_pc),
        .fetch_inst(fetch_inst), .i_cache_stall_req(i_cache_stall_req),
        .d_cache_stall_req(d_cache_stall_req), .exc_stall_req(exc_stall_req),
        .lsu1_tlb_stall_req(lsu1_tlb_stall_req), .exception_flush(exception_flush),
        .mem_refetch(mem_refetch), .fetch_ready(fetch_ready), .redirect_valid(redirect_valid),
        .redirect_pc(redirect_pc), .wb_valid(wb_valid), .wb_pc(wb_pc), .wb_inst(wb_inst)
    );

    assign pending = wr_idx - rd_idx;

    always @(posedge clk) begin
        if (rst_n && fetch_valid && fetch_ready) begin
            exp_pc[wr_idx]   <= fetch_pc;
            exp_inst[wr_idx] <= fetch_inst;
            exp_acc[wr_idx]  <= cyc;
            exp_gap[wr_idx]  <= tag_gap;
        end
    end

    always @(posedge clk or negedge rst_n) begin : ref_model
        logic [7:0] rd_n;
        logic [7:0] wr_n;
        if (!rst_n) begin
            rd_idx <= '0;
            wr_idx <= '0;
            keep_idx <= '0;
            cyc <= 0;
            last_ret <= 0;
            held_cnt <= 0;
            redirect_cnt <= 0;
            br_armed <= 1'b0;
        end else begin
            rd_n = rd_idx;
            wr_n = wr_idx;
            cyc <= cyc + 1;
            if (wb_valid && rd_n != wr_n) begin
                rd_n = rd_n + 8'd1;
                last_ret <= cyc;
            end
            if (fetch_valid && fetch_ready) begin
                // Everything fetched after the delay slot is wrong-path
                if (tag_slot) begin
                    keep_idx <= wr_n + 8'd1;
                    br_armed <= 1'b1;
                end
                wr_n = wr_n + 8'd1;
                if (fill_check) begin
                    held_cnt <= held_cnt + 1;
                end
            end
            if (redirect_valid) begin
                redirect_cnt <= redirect_cnt + 1;
                br_armed <= 1'b0;
                if (br_armed) begin
                    wr_n = keep_idx;
                end
            end
            // An exception or refetch drops every word still short of write-back
            if (exception_flush || mem_refetch) begin
                wr_n = rd_n;
            end
            rd_idx <= rd_n;
            wr_idx <= wr_n;
        end
    end

    function automatic void flag_mismatch(input string msg);
        err_count++;
        $display("[ERROR] %0t: %s (wb_pc %h, redirect_pc %h)", $time, msg, wb_pc, redirect_pc);
    endfunction

    a_order: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> (pending != 8'd0 && wb_pc == exp_pc[rd_idx] && wb_inst == exp_inst[rd_idx]))
        else flag_mismatch("retired word is not the oldest live accepted word");
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (lat_check && wb_valid) |-> cyc == exp_acc[rd_idx] + 6)
        else flag_mismatch("word did not retire 6 cycles after acceptance");
    a_deadline: assert property (@(posedge clk) disable iff (!rst_n)
        (lat_check && pending != 8'd0) |-> cyc <= exp_acc[rd_idx] + 6)
        else flag_mismatch("word overdue at write-back");
    a_cache_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (i_cache_stall_req || d_cache_stall_req) |-> !wb_valid)
        else flag_mismatch("word retired during a cache stall");
    a_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_valid && exp_gap[rd_idx]) |-> (cyc - last_ret) > 1)
        else flag_mismatch("load consumer retired right behind its load");
    a_target: assert property (@(posedge clk) disable iff (!rst_n)
        redirect_valid |-> (br_armed && redirect_pc == exp_target))
        else flag_mismatch("redirect without a branch or to the wrong target");
    a_fill: assert property (@(posedge clk) disable iff (!rst_n)
        fill_check |-> fetch_ready == (held_cnt < `FIFO_DEPTH))
        else flag_mismatch("fetch_ready does not follow FIFO occupancy");

    function automatic inst_u build_alu(input logic [3:0] rd, input logic [3:0] rs,
                                        input logic [3:0] rt);
        inst_u w;
        w.alu_fmt.op = OP_ALU;
        w.alu_fmt.rd = rd;
        w.alu_fmt.rs = rs;
        w.alu_fmt.rt = rt;
        return w;
    endfunction

    function automatic inst_u build_mem(input opcode_e op, input logic [3:0] rd,
                                        input logic [3:0] rs, input logic [3:0] off);
        inst_u w;
        w.mem_fmt.op  = op;
        w.mem_fmt.rd  = rd;
        w.mem_fmt.rs  = rs;
        w.mem_fmt.off = off;
        return w;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #10;
        end
    endtask

    // fetch_ready only changes at edges, so the value seen here is what the next edge samples
    task automatic push_word(input logic [`PC_W-1:0] pc, input inst_u inst,
                             input logic gap, input logic slot);
        logic taken;
        fetch_valid = 1'b1;
        fetch_pc = pc;
        fetch_inst = inst;
        tag_gap = gap;
        tag_slot = slot;
        taken = 1'b0;
        while (!taken) begin
            taken = fetch_ready;
            wait_cycles(1);
        end
        fetch_valid = 1'b0;
        tag_gap = 1'b0;
        tag_slot = 1'b0;
    endtask

    task automatic push_alu_words(input int n, input logic gaps);
        int r;
        for (int i = 0; i < n; i++) begin
            r = $random(seed);
            push_word(next_pc, build_alu(r[3:0], r[7:4], r[11:8]), 1'b0, 1'b0);
            next_pc = next_pc + 16'd1;
            if (gaps && r[12]) begin
                wait_cycles(1);
            end
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (pending != 8'd0 && n < DRAIN_LIMIT) begin
            wait_cycles(1);
            n++;
        end
        if (pending != 8'd0) begin
            err_count++;
            $display("Pipeline did not drain, %0d accepted words never retired", pending);
        end
        wait_cycles(2);
    endtask

    initial begin
        fetch_valid = 1'b0;
        fetch_pc = '0;
        fetch_inst = '0;
        i_cache_stall_req = 1'b0;
        d_cache_stall_req = 1'b0;
        exc_stall_req = 1'b0;
        lsu1_tlb_stall_req = 1'b0;
        exception_flush = 1'b0;
        mem_refetch = 1'b0;
        tag_gap = 1'b0;
        tag_slot = 1'b0;
        lat_check = 1'b0;
        fill_check = 1'b0;
        exp_target = '0;
        next_pc = 16'h0100;
        seed = 54519;
        err_count = 0;
        wait (rst_n === 1'b1);
        wait_cycles(1);
        if (fetch_ready !== 1'b1 || wb_valid !== 1'b0 || redirect_valid !== 1'b0) begin
            flag_mismatch("outputs not idle after reset");
        end

        // ALU-only stream with random fetch gaps
        lat_check = 1'b1;
        push_alu_words(12, 1'b1);
        wait_drain();
        lat_check = 1'b0;

        fork
            push_alu_words(14, 1'b0);
            begin
                wait_cycles(4);
                d_cache_stall_req = 1'b1;
                wait_cycles(5);
                d_cache_stall_req = 1'b0;
                wait_cycles(2);
                i_cache_stall_req = 1'b1;
                wait_cycles(3);
                i_cache_stall_req = 1'b0;
            end
        join
        wait_drain();

        fork
            push_alu_words(20, 1'b0);
            begin
                wait_cycles(7);
                exception_flush = 1'b1;
                wait_cycles(1);
                exception_flush = 1'b0;
                wait_cycles(4);
                mem_refetch = 1'b1;
                wait_cycles(1);
                mem_refetch = 1'b0;
            end
        join
        wait_drain();

        // Load into r5 with a consumer right behind it
        push_word(next_pc, build_mem(OP_LOAD, 4'd5, 4'd1, 4'd0), 1'b0, 1'b0);
        next_pc = next_pc + 16'd1;
        push_word(next_pc, build_alu(4'd6, 4'd5, 4'd2), 1'b1, 1'b0);
        next_pc = next_pc + 16'd1;
        push_alu_words(3, 1'b0);
        wait_drain();

        // Taken branch, delay slot, two wrong-path words, then the target stream
        exp_target = next_pc + 16'd1 + {{12{1'b0}}, 4'd5};
        push_word(next_pc, build_mem(OP_BRANCH, 4'd0, 4'd3, 4'd5), 1'b0, 1'b0);
        next_pc = next_pc + 16'd1;
        push_word(next_pc, build_alu(4'd7, 4'd8, 4'd9), 1'b0, 1'b1);
        next_pc = next_pc + 16'd1;
        push_alu_words(2, 1'b0);
        next_pc = exp_target;
        push_alu_words(4, 1'b0);
        wait_drain();

        i_cache_stall_req = 1'b1;
        fill_check = 1'b1;
        fork
            push_alu_words(7, 1'b0);
            begin
                wait_cycles(10);
                fill_check = 1'b0;
                i_cache_stall_req = 1'b0;
            end
        join
        wait_drain();

        if (redirect_cnt != 1) begin
            err_count++;
            $display("Expected exactly one redirect but saw %0d", redirect_cnt);
        end
        $display("Tests run: %0d, errors: %0d", NUM_TESTS, err_count);
        if (err_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(NUM_TESTS * 200 * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", NUM_TESTS * 200);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== pipe.f ====
+incdir+include
design/pipe_pkg.sv
design/pipe_ctrl.sv
design/inst_fifo.sv
design/stage_reg.sv
design/hazard_unit.sv
design/branch_unit.sv
design/pipe_top.sv
verification/clk_gen.sv
verification/pipe_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps -f pipe.f \
		--top-module pipe_tb -Mdir obj_dir -o pipe_sim
	./obj_dir/pipe_sim > sim.log 2>&1 || true
	cat sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
